// ==== rtl/stamofu_pkg.sv ====
// ROB index arithmetic wraps modulo 2**LOG_ROB_ENTRIES; fence sets use the RISC-V I,O,R,W order
package stamofu_pkg;

    // --------------------
    // ROB indexing

    // 128-entry ROB
    localparam int LOG_ROB_ENTRIES = 7;

    // absolute ROB index, compared modulo ROB size
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;

    // --------------------
    // operation classes

    // memory-ordering ops entering the store/AMO/fence unit
    typedef enum logic [1:0] {
        STAMOFU_OP_STORE = 2'b00,
        STAMOFU_OP_AMO   = 2'b01,
        STAMOFU_OP_FENCE = 2'b10
    } stamofu_op_t;

    // --------------------
    // fence set bits

    // bit positions inside a 4-bit pred or succ set
    // as in the instruction encoding: [3]=I [2]=O [1]=R [0]=W
    typedef enum logic [1:0] {
        FENCE_W = 2'd0,
        FENCE_R = 2'd1,
        FENCE_O = 2'd2,
        FENCE_I = 2'd3
    } fence_bit_t;

endpackage

// ==== rtl/pe_lsb.sv ====
// WIDTH must be at least 2; ack_mask is all ones when no request bit is set
`timescale 1ns/100ps

module pe_lsb #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0]         req_vec,
    output logic [WIDTH-1:0]         ack_one_hot,
    output logic [WIDTH-1:0]         ack_mask,
    output logic [$clog2(WIDTH)-1:0] ack_index
);

    localparam int INDEX_W = $clog2(WIDTH);

    // two's complement trick isolates the lowest set bit
    assign ack_one_hot = req_vec & (~req_vec + WIDTH'(1));

    // everything from bit 0 up through the granted bit
    assign ack_mask = req_vec ^ (req_vec - WIDTH'(1));

    // scan from the top so the lowest set bit is the last write
    always_comb begin
        ack_index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                ack_index = INDEX_W'(i);
            end
        end
    end

endmodule

// ==== rtl/stamofu_aq_decode.sv ====
// combinational only; an opcode outside the enum decodes as no acquire
`timescale 1ns/100ps

module stamofu_aq_decode (
    input  stamofu_pkg::stamofu_op_t enq_op,
    input  logic                     enq_aq,
    input  logic [3:0]               enq_fence_pred,
    input  logic [3:0]               enq_fence_succ,
    output logic                     enq_mem_aq,
    output logic                     enq_io_aq
);

    // --------------------
    // fence set classification

    // empty predecessor set orders nothing
    logic fence_pred_orders;

    // successor sets that hold back later accesses
    logic fence_succ_mem;
    logic fence_succ_io;

    assign fence_pred_orders = |enq_fence_pred;

    assign fence_succ_mem = enq_fence_succ[stamofu_pkg::FENCE_R]
                          | enq_fence_succ[stamofu_pkg::FENCE_W];

    assign fence_succ_io  = enq_fence_succ[stamofu_pkg::FENCE_I]
                          | enq_fence_succ[stamofu_pkg::FENCE_O];

    // --------------------
    // opcode decode

    always_comb begin
        enq_mem_aq = 1'b0;
        enq_io_aq  = 1'b0;
        case (enq_op)
            stamofu_pkg::STAMOFU_OP_STORE: begin
                // plain stores never acquire
                enq_mem_aq = 1'b0;
                enq_io_aq  = 1'b0;
            end
            stamofu_pkg::STAMOFU_OP_AMO: begin
                // aq bit applies to normal memory only
                enq_mem_aq = enq_aq;
                enq_io_aq  = 1'b0;
            end
            stamofu_pkg::STAMOFU_OP_FENCE: begin
                enq_mem_aq = fence_pred_orders & fence_succ_mem;
                enq_io_aq  = fence_pred_orders & fence_succ_io;
            end
            default: begin
                enq_mem_aq = 1'b0;
                enq_io_aq  = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/stamofu_aq.sv ====
// in-order collapsing queue; deq_valid must only pulse with entry 0 valid, advertisement lags one edge
`timescale 1ns/100ps

module stamofu_aq #(
    parameter int STAMOFU_AQ_ENTRIES = 4
) (
    input  logic                    CLK,
    input  logic                    nRST,

    // enqueue
    input  logic                    enq_valid,
    input  logic                    enq_mem_aq,
    input  logic                    enq_io_aq,
    input  stamofu_pkg::rob_index_t enq_rob_index,
    output logic                    enq_ready,

    // update bank 0
    input  logic                    update_bank0_valid,
    input  logic                    update_bank0_mem_aq,
    input  logic                    update_bank0_io_aq,
    input  stamofu_pkg::rob_index_t update_bank0_rob_index,

    // update bank 1
    input  logic                    update_bank1_valid,
    input  logic                    update_bank1_mem_aq,
    input  logic                    update_bank1_io_aq,
    input  stamofu_pkg::rob_index_t update_bank1_rob_index,

    // dequeue
    input  logic                    deq_valid,
    output stamofu_pkg::rob_index_t deq_rob_index,

    // ROB head and kill
    input  stamofu_pkg::rob_index_t rob_head_index,
    input  logic                    rob_kill_valid,
    input  stamofu_pkg::rob_index_t rob_kill_rel_index,

    // acquire advertisement
    output logic                    mem_aq_active,
    output stamofu_pkg::rob_index_t mem_aq_oldest_rob_index,
    output logic                    io_aq_active,
    output stamofu_pkg::rob_index_t io_aq_oldest_rob_index
);

    localparam int INDEX_W = $clog2(STAMOFU_AQ_ENTRIES);

    // --------------------
    // entry state

    logic [STAMOFU_AQ_ENTRIES-1:0]                          valid_q;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          killed_q;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          mem_aq_q;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          io_aq_q;
    stamofu_pkg::rob_index_t [STAMOFU_AQ_ENTRIES-1:0]       rob_index_q;

    // kill and update hits per entry
    stamofu_pkg::rob_index_t [STAMOFU_AQ_ENTRIES-1:0]       entry_age;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          new_kill;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          update_bank0_hit;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          update_bank1_hit;

    // source view with kill and update applied
    // slot STAMOFU_AQ_ENTRIES is an always-empty slot above the top entry
    logic [STAMOFU_AQ_ENTRIES:0]                            src_valid;
    logic [STAMOFU_AQ_ENTRIES:0]                            src_killed;
    logic [STAMOFU_AQ_ENTRIES:0]                            src_mem_aq;
    logic [STAMOFU_AQ_ENTRIES:0]                            src_io_aq;
    stamofu_pkg::rob_index_t [STAMOFU_AQ_ENTRIES:0]         src_rob_index;
    logic [STAMOFU_AQ_ENTRIES:0]                            src_enq;

    // enqueue slot select
    logic [STAMOFU_AQ_ENTRIES-1:0]                          free_vec;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          free_one_hot;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          enq_one_hot;

    // next entry state
    logic [STAMOFU_AQ_ENTRIES-1:0]                          next_valid;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          next_killed;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          next_mem_aq;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          next_io_aq;
    stamofu_pkg::rob_index_t [STAMOFU_AQ_ENTRIES-1:0]       next_rob_index;

    // advertisement search
    logic [STAMOFU_AQ_ENTRIES-1:0]                          mem_aq_req_vec;
    logic [STAMOFU_AQ_ENTRIES-1:0]                          io_aq_req_vec;
    logic [INDEX_W-1:0]                                     mem_aq_index;
    logic [INDEX_W-1:0]                                     io_aq_index;

    // --------------------
    // enqueue

    // valid entries are packed from 0, so lowest free is the tail
    assign free_vec = ~valid_q;

    pe_lsb #(
        .WIDTH(STAMOFU_AQ_ENTRIES)
    ) enq_pe_i (
        .req_vec    (free_vec),
        .ack_one_hot(free_one_hot),
        .ack_mask   (),
        .ack_index  ()
    );

    assign enq_one_hot = free_one_hot & {STAMOFU_AQ_ENTRIES{enq_valid}};
    assign enq_ready   = |free_vec;

    // --------------------
    // kill, update and source view

    always_comb begin
        for (int i = 0; i < STAMOFU_AQ_ENTRIES; i++) begin
            // distance from ROB head, wraps with the ROB
            entry_age[i] = rob_index_q[i] - rob_head_index;
            new_kill[i]  = rob_kill_valid & (entry_age[i] >= rob_kill_rel_index);

            update_bank0_hit[i] = update_bank0_valid
                                & (update_bank0_rob_index == rob_index_q[i]);
            update_bank1_hit[i] = update_bank1_valid
                                & (update_bank1_rob_index == rob_index_q[i]);

            src_valid[i]     = valid_q[i];
            src_killed[i]    = killed_q[i] | new_kill[i];
            src_rob_index[i] = rob_index_q[i];
            src_enq[i]       = enq_one_hot[i];

            // bank 0 has priority on a double hit
            if (update_bank0_hit[i]) begin
                src_mem_aq[i] = update_bank0_mem_aq;
                src_io_aq[i]  = update_bank0_io_aq;
            end else if (update_bank1_hit[i]) begin
                src_mem_aq[i] = update_bank1_mem_aq;
                src_io_aq[i]  = update_bank1_io_aq;
            end else begin
                src_mem_aq[i] = mem_aq_q[i];
                src_io_aq[i]  = io_aq_q[i];
            end
        end

        // nothing lives above the top entry
        src_valid[STAMOFU_AQ_ENTRIES]     = 1'b0;
        src_killed[STAMOFU_AQ_ENTRIES]    = 1'b0;
        src_mem_aq[STAMOFU_AQ_ENTRIES]    = 1'b0;
        src_io_aq[STAMOFU_AQ_ENTRIES]     = 1'b0;
        src_rob_index[STAMOFU_AQ_ENTRIES] = '0;
        src_enq[STAMOFU_AQ_ENTRIES]       = 1'b0;
    end

    // --------------------
    // collapse select

    always_comb begin
        int src_sel;
        for (int i = 0; i < STAMOFU_AQ_ENTRIES; i++) begin
            // dequeue shifts everything down one place
            src_sel = deq_valid ? i + 1 : i;

            if (src_valid[src_sel]) begin
                next_valid[i]     = 1'b1;
                next_killed[i]    = src_killed[src_sel];
                next_mem_aq[i]    = src_mem_aq[src_sel];
                next_io_aq[i]     = src_io_aq[src_sel];
                next_rob_index[i] = src_rob_index[src_sel];
            end else begin
                // empty source, so take the enqueue if it targets that slot
                next_valid[i]     = src_enq[src_sel];
                next_killed[i]    = 1'b0;
                next_mem_aq[i]    = enq_mem_aq;
                next_io_aq[i]     = enq_io_aq;
                next_rob_index[i] = enq_rob_index;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q     <= '0;
            killed_q    <= '0;
            mem_aq_q    <= '0;
            io_aq_q     <= '0;
            rob_index_q <= '0;
        end else begin
            valid_q     <= next_valid;
            killed_q    <= next_killed;
            mem_aq_q    <= next_mem_aq;
            io_aq_q     <= next_io_aq;
            rob_index_q <= next_rob_index;
        end
    end

    // head of queue for the commit side
    assign deq_rob_index = rob_index_q[0];

    // --------------------
    // acquire advertisement

    assign mem_aq_req_vec = valid_q & ~killed_q & mem_aq_q;
    assign io_aq_req_vec  = valid_q & ~killed_q & io_aq_q;

    pe_lsb #(
        .WIDTH(STAMOFU_AQ_ENTRIES)
    ) mem_aq_pe_i (
        .req_vec    (mem_aq_req_vec),
        .ack_one_hot(),
        .ack_mask   (),
        .ack_index  (mem_aq_index)
    );

    pe_lsb #(
        .WIDTH(STAMOFU_AQ_ENTRIES)
    ) io_aq_pe_i (
        .req_vec    (io_aq_req_vec),
        .ack_one_hot(),
        .ack_mask   (),
        .ack_index  (io_aq_index)
    );

    // registered so load-side timing sees a flop
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_aq_active           <= 1'b0;
            mem_aq_oldest_rob_index <= '0;
            io_aq_active            <= 1'b0;
            io_aq_oldest_rob_index  <= '0;
        end else begin
            mem_aq_active           <= |mem_aq_req_vec;
            mem_aq_oldest_rob_index <= rob_index_q[mem_aq_index];
            io_aq_active            <= |io_aq_req_vec;
            io_aq_oldest_rob_index  <= rob_index_q[io_aq_index];
        end
    end

endmodule

// ==== rtl/stamofu_aq_top.sv ====
// no added registers; the enqueue side must hold its op while enq_ready is low
`timescale 1ns/100ps

module stamofu_aq_top #(
    parameter int STAMOFU_AQ_ENTRIES = 4
) (
    input  logic                      CLK,
    input  logic                      nRST,

    // raw op enqueue
    input  logic                      enq_valid,
    input  stamofu_pkg::stamofu_op_t  enq_op,
    input  logic                      enq_aq,
    input  logic [3:0]                enq_fence_pred,
    input  logic [3:0]                enq_fence_succ,
    input  stamofu_pkg::rob_index_t   enq_rob_index,
    output logic                      enq_ready,

    // update banks
    input  logic                      update_bank0_valid,
    input  logic                      update_bank0_mem_aq,
    input  logic                      update_bank0_io_aq,
    input  stamofu_pkg::rob_index_t   update_bank0_rob_index,
    input  logic                      update_bank1_valid,
    input  logic                      update_bank1_mem_aq,
    input  logic                      update_bank1_io_aq,
    input  stamofu_pkg::rob_index_t   update_bank1_rob_index,

    // dequeue
    input  logic                      deq_valid,
    output stamofu_pkg::rob_index_t   deq_rob_index,

    // ROB head and kill
    input  stamofu_pkg::rob_index_t   rob_head_index,
    input  logic                      rob_kill_valid,
    input  stamofu_pkg::rob_index_t   rob_kill_rel_index,

    // acquire advertisement
    output logic                      mem_aq_active,
    output stamofu_pkg::rob_index_t   mem_aq_oldest_rob_index,
    output logic                      io_aq_active,
    output stamofu_pkg::rob_index_t   io_aq_oldest_rob_index
);

    // decoded acquire flags into the queue
    logic enq_mem_aq;
    logic enq_io_aq;

    stamofu_aq_decode stamofu_aq_decode_i (
        .enq_op        (enq_op),
        .enq_aq        (enq_aq),
        .enq_fence_pred(enq_fence_pred),
        .enq_fence_succ(enq_fence_succ),
        .enq_mem_aq    (enq_mem_aq),
        .enq_io_aq     (enq_io_aq)
    );

    stamofu_aq #(
        .STAMOFU_AQ_ENTRIES(STAMOFU_AQ_ENTRIES)
    ) stamofu_aq_i (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .enq_valid              (enq_valid),
        .enq_mem_aq             (enq_mem_aq),
        .enq_io_aq              (enq_io_aq),
        .enq_rob_index          (enq_rob_index),
        .enq_ready              (enq_ready),
        .update_bank0_valid     (update_bank0_valid),
        .update_bank0_mem_aq    (update_bank0_mem_aq),
        .update_bank0_io_aq     (update_bank0_io_aq),
        .update_bank0_rob_index (update_bank0_rob_index),
        .update_bank1_valid     (update_bank1_valid),
        .update_bank1_mem_aq    (update_bank1_mem_aq),
        .update_bank1_io_aq     (update_bank1_io_aq),
        .update_bank1_rob_index (update_bank1_rob_index),
        .deq_valid              (deq_valid),
        .deq_rob_index          (deq_rob_index),
        .rob_head_index         (rob_head_index),
        .rob_kill_valid         (rob_kill_valid),
        .rob_kill_rel_index     (rob_kill_rel_index),
        .mem_aq_active          (mem_aq_active),
        .mem_aq_oldest_rob_index(mem_aq_oldest_rob_index),
        .io_aq_active           (io_aq_active),
        .io_aq_oldest_rob_index (io_aq_oldest_rob_index)
    );

endmodule

// ==== verif/stamofu_aq_sva.sv ====
// bound into every stamofu_aq; reads the entry registers directly by name
`timescale 1ns/100ps

module stamofu_aq_sva #(
    parameter int STAMOFU_AQ_ENTRIES = 4
) (
    input logic                                           CLK,
    input logic                                           nRST,
    input logic                                           enq_ready,
    input logic                                           deq_valid,
    input logic [STAMOFU_AQ_ENTRIES-1:0]                  valid_q,
    input logic [STAMOFU_AQ_ENTRIES-1:0]                  killed_q,
    input stamofu_pkg::rob_index_t [STAMOFU_AQ_ENTRIES-1:0] rob_index_q,
    input logic                                           mem_aq_active,
    input stamofu_pkg::rob_index_t                        mem_aq_oldest_rob_index,
    input logic                                           io_aq_active,
    input stamofu_pkg::rob_index_t                        io_aq_oldest_rob_index
);

    // live entries as they stood one edge ago
    logic [STAMOFU_AQ_ENTRIES-1:0]                    prev_live;
    stamofu_pkg::rob_index_t [STAMOFU_AQ_ENTRIES-1:0] prev_rob;
    logic                                             mem_named;
    logic                                             io_named;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            prev_live <= '0;
            prev_rob  <= '0;
        end else begin
            prev_live <= valid_q & ~killed_q;
            prev_rob  <= rob_index_q;
        end
    end

    always_comb begin
        mem_named = 1'b0;
        io_named  = 1'b0;
        for (int i = 0; i < STAMOFU_AQ_ENTRIES; i++) begin
            mem_named = mem_named | (prev_live[i] & (prev_rob[i] == mem_aq_oldest_rob_index));
            io_named  = io_named | (prev_live[i] & (prev_rob[i] == io_aq_oldest_rob_index));
        end
    end

    // a refused enqueue must leave the full queue untouched
    full_no_growth: assert property (@(posedge CLK) disable iff (!nRST)
        (!enq_ready && !deq_valid) |=> ($stable(valid_q) && $stable(rob_index_q)))
        else $error("queue entries changed while enq_ready was low and no dequeue happened");

    adv_names_live: assert property (@(posedge CLK) disable iff (!nRST)
        (!mem_aq_active || mem_named) && (!io_aq_active || io_named))
        else $error("advertised acquire index was not held by a live entry one cycle before");

    // valid bits form 0..01..1
    valid_packed: assert property (@(posedge CLK) disable iff (!nRST)
        (valid_q & (valid_q + STAMOFU_AQ_ENTRIES'(1))) == '0)
        else $error("valid entries are not contiguous from entry 0");

endmodule

bind stamofu_aq stamofu_aq_sva #(
    .STAMOFU_AQ_ENTRIES(STAMOFU_AQ_ENTRIES)
) stamofu_aq_sva_i (
    .CLK                    (CLK),
    .nRST                   (nRST),
    .enq_ready              (enq_ready),
    .deq_valid              (deq_valid),
    .valid_q                (valid_q),
    .killed_q               (killed_q),
    .rob_index_q            (rob_index_q),
    .mem_aq_active          (mem_aq_active),
    .mem_aq_oldest_rob_index(mem_aq_oldest_rob_index),
    .io_aq_active           (io_aq_active),
    .io_aq_oldest_rob_index (io_aq_oldest_rob_index)
);

// ==== verif/stamofu_aq_tb.sv ====
// drives the top level with ENTRIES=4; dequeue is only requested while the model queue is non-empty
`timescale 1ns/100ps

module stamofu_aq_tb;

    localparam int ENTRIES         = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 100;
    localparam int RANDOM_CYCLES   = 800;
    localparam int CYCLE_LIMIT = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 3 / 2;

    logic                     CLK;
    logic                     nRST;
    logic                     enq_valid;
    stamofu_pkg::stamofu_op_t enq_op;
    logic                     enq_aq;
    logic [3:0]               enq_fence_pred;
    logic [3:0]               enq_fence_succ;
    stamofu_pkg::rob_index_t  enq_rob_index;
    logic                     enq_ready;
    logic                     update_bank0_valid;
    logic                     update_bank0_mem_aq;
    logic                     update_bank0_io_aq;
    stamofu_pkg::rob_index_t  update_bank0_rob_index;
    logic                     update_bank1_valid;
    logic                     update_bank1_mem_aq;
    logic                     update_bank1_io_aq;
    stamofu_pkg::rob_index_t  update_bank1_rob_index;
    logic                     deq_valid;
    stamofu_pkg::rob_index_t  deq_rob_index;
    stamofu_pkg::rob_index_t  rob_head_index;
    logic                     rob_kill_valid;
    stamofu_pkg::rob_index_t  rob_kill_rel_index;
    logic                     mem_aq_active;
    logic                     io_aq_active;
    stamofu_pkg::rob_index_t  mem_aq_oldest_rob_index;
    stamofu_pkg::rob_index_t  io_aq_oldest_rob_index;

    // model of the queue after the last edge
    int                       m_count;
    stamofu_pkg::rob_index_t  m_rob [ENTRIES];
    logic                     m_mem [ENTRIES];
    logic                     m_io [ENTRIES];
    logic                     m_killed [ENTRIES];

    string cur_test;
    int    err_count;
    int    check_count;
    int    test_err_base;
    int    tests_run;
    int    tests_failed;
    int    cycle_count;

    stamofu_aq_top #(
        .STAMOFU_AQ_ENTRIES(ENTRIES)
    ) stamofu_aq_top_i (.*);

    initial begin
        CLK = 1'b0;
        forever begin
            #20 CLK = ~CLK;
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // --------------------
    // reference model

    // returns {mem_aq, io_aq}
    function automatic logic [1:0] decode_ref(input logic [1:0] op, input logic aq,
                                              input logic [3:0] pred, input logic [3:0] succ);
        logic ordered;
        logic mem_hit;
        logic io_hit;
        ordered = pred != 4'b0000;
        mem_hit = succ[stamofu_pkg::FENCE_R] | succ[stamofu_pkg::FENCE_W];
        io_hit  = succ[stamofu_pkg::FENCE_I] | succ[stamofu_pkg::FENCE_O];
        case (op)
            stamofu_pkg::STAMOFU_OP_AMO:   return {aq, 1'b0};
            stamofu_pkg::STAMOFU_OP_FENCE: return {ordered & mem_hit, ordered & io_hit};
            default:                       return 2'b00;
        endcase
    endfunction

    // oldest live entry with the chosen flag, as {active, rob index}
    function automatic logic [7:0] advertise(input logic io_kind);
        logic [7:0] result;
        result = 8'h00;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (i < m_count && !m_killed[i] && (io_kind ? m_io[i] : m_mem[i])) begin
                result = {1'b1, m_rob[i]};
            end
        end
        return result;
    endfunction

    // kill and update on old entries, then dequeue, then enqueue
    task automatic apply_edge();
        stamofu_pkg::rob_index_t age;
        logic [1:0]              flags;
        logic                    took_enq;
        took_enq = enq_valid && m_count < ENTRIES;
        for (int i = 0; i < m_count; i++) begin
            age = m_rob[i] - rob_head_index;
            if (rob_kill_valid && age >= rob_kill_rel_index) begin
                m_killed[i] = 1'b1;
            end
            if (update_bank0_valid && update_bank0_rob_index == m_rob[i]) begin
                m_mem[i] = update_bank0_mem_aq;
                m_io[i]  = update_bank0_io_aq;
            end else if (update_bank1_valid && update_bank1_rob_index == m_rob[i]) begin
                m_mem[i] = update_bank1_mem_aq;
                m_io[i]  = update_bank1_io_aq;
            end
        end
        if (deq_valid && m_count > 0) begin
            for (int i = 0; i < ENTRIES - 1; i++) begin
                m_rob[i]    = m_rob[i + 1];
                m_mem[i]    = m_mem[i + 1];
                m_io[i]     = m_io[i + 1];
                m_killed[i] = m_killed[i + 1];
            end
            m_count--;
        end
        if (took_enq) begin
            flags = decode_ref(enq_op, enq_aq, enq_fence_pred, enq_fence_succ);
            m_rob[m_count]    = enq_rob_index;
            m_mem[m_count]    = flags[1];
            m_io[m_count]     = flags[0];
            m_killed[m_count] = 1'b0;
            m_count++;
        end
    endtask

    task automatic check(input string what, input logic [7:0] expected, input logic [7:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    // outputs settle just after the edge; inputs were driven on the falling edge before
    initial begin : compare_proc
        logic [7:0] exp_mem;
        logic [7:0] exp_io;
        forever begin
            @(posedge CLK);
            #1;
            if (nRST) begin
                exp_mem = advertise(1'b0);
                exp_io  = advertise(1'b1);
                apply_edge();
                check("enq_ready", 8'(m_count < ENTRIES), 8'(enq_ready));
                if (m_count > 0) begin
                    check("deq_rob_index", 8'(m_rob[0]), 8'(deq_rob_index));
                end
                check("mem_aq_active", 8'(exp_mem[7]), 8'(mem_aq_active));
                check("io_aq_active", 8'(exp_io[7]), 8'(io_aq_active));
                if (exp_mem[7]) begin
                    check("mem_aq_oldest", 8'(exp_mem[6:0]), 8'(mem_aq_oldest_rob_index));
                end
                if (exp_io[7]) begin
                    check("io_aq_oldest", 8'(exp_io[6:0]), 8'(io_aq_oldest_rob_index));
                end
            end
        end
    end

    // --------------------
    // stimulus

    task automatic clear_valids();
        {enq_valid, update_bank0_valid, update_bank1_valid, deq_valid, rob_kill_valid} = '0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            clear_valids();
        end
    endtask

    task automatic push(input stamofu_pkg::stamofu_op_t op, input logic aq,
                        input logic [3:0] pred, input logic [3:0] succ, input int rob,
                        input logic hold, input logic deq);
        @(negedge CLK);
        clear_valids();
        enq_valid      = 1'b1;
        enq_op         = op;
        enq_aq         = aq;
        enq_fence_pred = pred;
        enq_fence_succ = succ;
        enq_rob_index  = 7'(rob);
        deq_valid      = deq;
        while (hold && !enq_ready) begin
            @(negedge CLK);
        end
    endtask

    task automatic drain();
        @(negedge CLK);
        clear_valids();
        while (m_count > 0) begin
            deq_valid = 1'b1;
            @(negedge CLK);
            clear_valids();
        end
    endtask

    task automatic update(input logic v0, input logic mem0, input logic io0, input int rob0,
                          input logic v1, input logic mem1, input logic io1, input int rob1);
        @(negedge CLK);
        clear_valids();
        {update_bank0_valid, update_bank0_mem_aq, update_bank0_io_aq} = {v0, mem0, io0};
        {update_bank1_valid, update_bank1_mem_aq, update_bank1_io_aq} = {v1, mem1, io1};
        update_bank0_rob_index = 7'(rob0);
        update_bank1_rob_index = 7'(rob1);
    endtask

    task automatic kill(input int head, input int rel);
        @(negedge CLK);
        clear_valids();
        rob_kill_valid     = 1'b1;
        rob_head_index     = 7'(head);
        rob_kill_rel_index = 7'(rel);
    endtask

    task automatic finish_test();
        idle(2);
        tests_run++;
        if (err_count != test_err_base) begin
            tests_failed++;
        end
        $display("test %-8s done, %0d errors", cur_test, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    // --------------------
    // test sequence

    initial begin : main_proc
        int pick;
        void'($urandom(54));
        nRST = 1'b0;
        clear_valids();
        enq_op = stamofu_pkg::STAMOFU_OP_STORE;
        {enq_aq, enq_fence_pred, enq_fence_succ, enq_rob_index} = '0;
        {update_bank0_mem_aq, update_bank0_io_aq, update_bank0_rob_index} = '0;
        {update_bank1_mem_aq, update_bank1_io_aq, update_bank1_rob_index} = '0;
        {rob_head_index, rob_kill_rel_index} = '0;

        cur_test = "reset";
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        check("enq_ready", 8'h01, 8'(enq_ready));
        check("mem_aq_active", 8'h00, 8'(mem_aq_active));
        check("io_aq_active", 8'h00, 8'(io_aq_active));
        check("mem_aq_oldest", 8'h00, 8'(mem_aq_oldest_rob_index));
        check("io_aq_oldest", 8'h00, 8'(io_aq_oldest_rob_index));
        finish_test();

        // fence sets are I,O,R,W from msb
        cur_test = "decode";
        push(stamofu_pkg::STAMOFU_OP_STORE, 1'b1, 4'b1111, 4'b1111, 5, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b0, 4'b0000, 4'b0000, 6, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b1, 4'b0000, 4'b0000, 7, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b0000, 4'b1111, 8, 1'b1, 1'b0);
        drain();
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b0010, 4'b1100, 9, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b0001, 4'b0011, 10, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b1111, 4'b1111, 11, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b1000, 4'b0000, 12, 1'b1, 1'b0);
        drain();
        finish_test();

        cur_test = "full";
        push(stamofu_pkg::STAMOFU_OP_STORE, 1'b0, 4'b0000, 4'b0000, 40, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b1, 4'b0000, 4'b0000, 41, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b0011, 4'b0100, 42, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b1, 4'b0000, 4'b0000, 43, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b1, 4'b0000, 4'b0000, 44, 1'b0, 1'b0);
        drain_one: begin
            @(negedge CLK);
            clear_valids();
            deq_valid = 1'b1;
        end
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b1111, 4'b1000, 45, 1'b0, 1'b1);
        drain();
        finish_test();

        cur_test = "update";
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b1, 4'b0000, 4'b0000, 30, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b0, 4'b0000, 4'b0000, 31, 1'b1, 1'b0);
        update(1'b0, 1'b0, 1'b0, 0, 1'b1, 1'b0, 1'b1, 31);
        update(1'b1, 1'b0, 1'b1, 30, 1'b1, 1'b1, 1'b0, 30);
        idle(2);
        drain();
        finish_test();

        // head near the ROB wrap point
        cur_test = "kill";
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b1, 4'b0000, 4'b0000, 126, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b0011, 4'b1100, 127, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_FENCE, 1'b0, 4'b1111, 4'b1111, 0, 1'b1, 1'b0);
        push(stamofu_pkg::STAMOFU_OP_AMO, 1'b1, 4'b0000, 4'b0000, 1, 1'b1, 1'b0);
        kill(126, 2);
        idle(2);
        kill(126, 1);
        idle(2);
        drain();
        finish_test();

        cur_test = "random";
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            @(negedge CLK);
            clear_valids();
            enq_valid      = 1'($urandom_range(0, 1));
            enq_op         = stamofu_pkg::stamofu_op_t'(2'($urandom_range(0, 2)));
            enq_aq         = 1'($urandom_range(0, 1));
            enq_fence_pred = 4'($urandom);
            enq_fence_succ = 4'($urandom);
            enq_rob_index  = 7'($urandom);
            // aim updates at live entries most of the time
            pick = (m_count > 0) ? $urandom_range(0, m_count - 1) : 0;
            update_bank0_valid = ($urandom_range(0, 3) == 0);
            {update_bank0_mem_aq, update_bank0_io_aq} = 2'($urandom);
            update_bank0_rob_index = m_rob[pick];
            update_bank1_valid = ($urandom_range(0, 3) == 0);
            {update_bank1_mem_aq, update_bank1_io_aq} = 2'($urandom);
            update_bank1_rob_index = $urandom_range(0, 1) ? m_rob[pick] : 7'($urandom);
            rob_kill_valid     = ($urandom_range(0, 15) == 0);
            rob_head_index     = 7'($urandom);
            rob_kill_rel_index = 7'($urandom);
            deq_valid = (m_count > 0) && ($urandom_range(0, 9) < 3);
        end
        drain();
        finish_test();

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== stamofu_aq.f ====
rtl/stamofu_pkg.sv
rtl/pe_lsb.sv
rtl/stamofu_aq_decode.sv
rtl/stamofu_aq.sv
rtl/stamofu_aq_top.sv
verif/stamofu_aq_sva.sv
verif/stamofu_aq_tb.sv

// ==== Makefile ====
# Verilator flow for the stamofu acquire queue testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f stamofu_aq.f --top-module stamofu_aq_tb -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
